//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = eth_tb
FILELIST  = compile.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- compile.f
design/eth_pkg.sv
design/eth_rx_parser.sv
design/eth_tx_framer.sv
design/udp_port_switch.sv
design/eth_top.sv
dv/tb_clock.sv
dv/eth_tb.sv

//--- design/eth_pkg.sv
/*
 * UDP/IPv4 stack shared types
 * Stream beat, transmit and receive header structs, protocol constants
 * and the state encodings of the parser and framer
 */

package eth_pkg;

   // One byte of a frame or payload stream
   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } byte_beat_t;

   // Transmit request from a user port
   typedef struct packed {
      logic [47:0] dst_mac;
      logic [31:0] dst_ip;
      logic [15:0] src_port;
      logic [15:0] dst_port;
      logic [15:0] length;  // UDP payload bytes
      logic [15:0] pad;
   } udp_tx_hdr_t;

   // Header of a received datagram
   typedef struct packed {
      logic [47:0] src_mac;
      logic [31:0] src_ip;
      logic [15:0] src_port;
      logic [15:0] dst_port;
      logic [15:0] length;  // UDP payload bytes
   } udp_rx_hdr_t;

   localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
   localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
   localparam int          HDR_BYTES      = 42;  // Ethernet 14, IPv4 20, UDP 8

   typedef enum logic [1:0] {
      RX_HDR,
      RX_PAYLOAD,
      RX_DROP
   } rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_HDR,
      TX_PAYLOAD
   } tx_state_e;

   // Port number table, entry 0 in the low bits
   localparam int MAX_PORTS = 8;
   typedef logic [MAX_PORTS-1:0][15:0] port_list_t;

endpackage

//--- design/eth_rx_parser.sv
/*
 * Receive parser
 * Checks and captures the Ethernet, IPv4 and UDP headers, then passes
 * the UDP payload trimmed to its length; other frames are drained
 */

`timescale 1ns/1ns

module eth_rx_parser (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [47:0]          local_mac,
   input  logic [31:0]          local_ip,
   input  eth_pkg::byte_beat_t  mac_rx,
   input  logic                 mac_rx_valid,
   output logic                 mac_rx_ready,
   output eth_pkg::udp_rx_hdr_t hdr,
   output logic                 hdr_valid,
   input  logic                 hdr_ready,
   output eth_pkg::byte_beat_t  data,
   output logic                 data_valid,
   input  logic                 data_ready
);
   import eth_pkg::*;

   rx_state_e   state;
   logic [5:0]  cnt;        // Header byte index
   logic [15:0] remain;     // Payload bytes still to pass
   logic        mac_local;
   logic        mac_bcast;
   logic        fields_ok;
   logic        en_q;
   logic        take;
   logic [7:0]  b;

   assign take = mac_rx_valid && mac_rx_ready;
   assign b    = mac_rx.data;

   always_comb begin
      case (state)
         RX_HDR:     mac_rx_ready = en_q;
         RX_PAYLOAD: mac_rx_ready = data_ready && !hdr_valid;
         default:    mac_rx_ready = 1'b1;  // Drain
      endcase
   end

   // Payload goes straight through once the header is taken
   assign data_valid = (state == RX_PAYLOAD) && !hdr_valid && mac_rx_valid;
   assign data.data  = mac_rx.data;
   assign data.last  = mac_rx.last || (remain == 16'd1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= RX_HDR;
         cnt       <= '0;
         remain    <= '0;
         mac_local <= 1'b1;
         mac_bcast <= 1'b1;
         fields_ok <= 1'b1;
         hdr_valid <= 1'b0;
         en_q      <= 1'b0;
      end else begin
         en_q <= 1'b1;
         if (hdr_valid && hdr_ready)
            hdr_valid <= 1'b0;
         case (state)
            RX_HDR: if (take) begin
               cnt <= cnt + 6'd1;
               case (cnt) inside
                  [6'd0:6'd5]: begin
                     if (b != local_mac[47 - 8*cnt -: 8]) mac_local <= 1'b0;
                     if (b != 8'hff) mac_bcast <= 1'b0;
                  end
                  6'd12:  if (b != ETHERTYPE_IPV4[15:8]) fields_ok <= 1'b0;
                  6'd13:  if (b != ETHERTYPE_IPV4[7:0]) fields_ok <= 1'b0;
                  6'd14:  if (b != 8'h45) fields_ok <= 1'b0;  // No options
                  6'd23:  if (b != IP_PROTO_UDP) fields_ok <= 1'b0;
                  [6'd30:6'd33]:
                     if (b != local_ip[31 - 8*(cnt - 6'd30) -: 8]) fields_ok <= 1'b0;
                  6'd39:  if ({hdr.length[7:0], b} <= 16'd8) fields_ok <= 1'b0;
                  default: ;
               endcase
               if (mac_rx.last || cnt == 6'd41) begin
                  // Frame header done or frame cut short
                  cnt       <= '0;
                  mac_local <= 1'b1;
                  mac_bcast <= 1'b1;
                  fields_ok <= 1'b1;
                  if (!mac_rx.last) begin
                     if ((mac_local || mac_bcast) && fields_ok) begin
                        hdr_valid <= 1'b1;
                        remain    <= hdr.length;
                        state     <= RX_PAYLOAD;
                     end else begin
                        state <= RX_DROP;
                     end
                  end
               end
            end
            RX_PAYLOAD: if (take) begin
               remain <= remain - 16'd1;
               if (data.last)
                  state <= mac_rx.last ? RX_HDR : RX_DROP;  // Skip Ethernet padding
            end
            default: if (take && mac_rx.last) state <= RX_HDR;
         endcase
      end
   end

   // Header fields shift in as their bytes arrive
   always_ff @(posedge clk) begin
      if (state == RX_HDR && take) begin
         case (cnt) inside
            [6'd6:6'd11]:  hdr.src_mac  <= {hdr.src_mac[39:0], b};
            [6'd26:6'd29]: hdr.src_ip   <= {hdr.src_ip[23:0], b};
            6'd34, 6'd35:  hdr.src_port <= {hdr.src_port[7:0], b};
            6'd36, 6'd37:  hdr.dst_port <= {hdr.dst_port[7:0], b};
            6'd38:         hdr.length   <= {8'h00, b};
            6'd39:         hdr.length   <= {hdr.length[7:0], b} - 16'd8;  // UDP header off
            default: ;
         endcase
      end
   end

endmodule

//--- design/eth_top.sv
/*
 * UDP/IPv4 over Ethernet stack top
 * Receive parser, transmit framer and the user port switch
 */

`timescale 1ns/1ns

module eth_top #(
   parameter int                  PORT_COUNT = 2,
   parameter eth_pkg::port_list_t PORTS      = {96'd0, 16'd5678, 16'd1234}
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  eth_pkg::byte_beat_t                   mac_rx,
   input  logic                                  mac_rx_valid,
   output logic                                  mac_rx_ready,
   output eth_pkg::byte_beat_t                   mac_tx,
   output logic                                  mac_tx_valid,
   input  logic                                  mac_tx_ready,
   input  eth_pkg::udp_tx_hdr_t [PORT_COUNT-1:0] udp_tx_hdr,
   input  logic [PORT_COUNT-1:0]                 udp_tx_hdr_valid,
   output logic [PORT_COUNT-1:0]                 udp_tx_hdr_ready,
   input  eth_pkg::byte_beat_t  [PORT_COUNT-1:0] udp_tx_data,
   input  logic [PORT_COUNT-1:0]                 udp_tx_data_valid,
   output logic [PORT_COUNT-1:0]                 udp_tx_data_ready,
   output eth_pkg::udp_rx_hdr_t [PORT_COUNT-1:0] udp_rx_hdr,
   output logic [PORT_COUNT-1:0]                 udp_rx_hdr_valid,
   input  logic [PORT_COUNT-1:0]                 udp_rx_hdr_ready,
   output eth_pkg::byte_beat_t  [PORT_COUNT-1:0] udp_rx_data,
   output logic [PORT_COUNT-1:0]                 udp_rx_data_valid,
   input  logic [PORT_COUNT-1:0]                 udp_rx_data_ready,
   input  logic [47:0]                           local_mac,
   input  logic [31:0]                           local_ip
);
   import eth_pkg::*;

   udp_rx_hdr_t rx_hdr;
   logic        rx_hdr_valid;
   logic        rx_hdr_ready;
   byte_beat_t  rx_data;
   logic        rx_data_valid;
   logic        rx_data_ready;
   udp_tx_hdr_t tx_hdr;
   logic        tx_hdr_valid;
   logic        tx_hdr_ready;
   byte_beat_t  tx_data;
   logic        tx_data_valid;
   logic        tx_data_ready;

   eth_rx_parser u_rx_parser (
      .clk          (clk),
      .rst_n        (rst_n),
      .local_mac    (local_mac),
      .local_ip     (local_ip),
      .mac_rx       (mac_rx),
      .mac_rx_valid (mac_rx_valid),
      .mac_rx_ready (mac_rx_ready),
      .hdr          (rx_hdr),
      .hdr_valid    (rx_hdr_valid),
      .hdr_ready    (rx_hdr_ready),
      .data         (rx_data),
      .data_valid   (rx_data_valid),
      .data_ready   (rx_data_ready)
   );

   eth_tx_framer u_tx_framer (
      .clk          (clk),
      .rst_n        (rst_n),
      .local_mac    (local_mac),
      .local_ip     (local_ip),
      .hdr          (tx_hdr),
      .hdr_valid    (tx_hdr_valid),
      .hdr_ready    (tx_hdr_ready),
      .data         (tx_data),
      .data_valid   (tx_data_valid),
      .data_ready   (tx_data_ready),
      .mac_tx       (mac_tx),
      .mac_tx_valid (mac_tx_valid),
      .mac_tx_ready (mac_tx_ready)
   );

   udp_port_switch #(
      .PORT_COUNT (PORT_COUNT),
      .PORTS      (PORTS)
   ) u_port_switch (
      .clk                 (clk),
      .rst_n               (rst_n),
      .user_tx_hdr         (udp_tx_hdr),
      .user_tx_hdr_valid   (udp_tx_hdr_valid),
      .user_tx_hdr_ready   (udp_tx_hdr_ready),
      .user_tx_data        (udp_tx_data),
      .user_tx_data_valid  (udp_tx_data_valid),
      .user_tx_data_ready  (udp_tx_data_ready),
      .user_rx_hdr         (udp_rx_hdr),
      .user_rx_hdr_valid   (udp_rx_hdr_valid),
      .user_rx_hdr_ready   (udp_rx_hdr_ready),
      .user_rx_data        (udp_rx_data),
      .user_rx_data_valid  (udp_rx_data_valid),
      .user_rx_data_ready  (udp_rx_data_ready),
      .stack_tx_hdr        (tx_hdr),
      .stack_tx_hdr_valid  (tx_hdr_valid),
      .stack_tx_hdr_ready  (tx_hdr_ready),
      .stack_tx_data       (tx_data),
      .stack_tx_data_valid (tx_data_valid),
      .stack_tx_data_ready (tx_data_ready),
      .stack_rx_hdr        (rx_hdr),
      .stack_rx_hdr_valid  (rx_hdr_valid),
      .stack_rx_hdr_ready  (rx_hdr_ready),
      .stack_rx_data       (rx_data),
      .stack_rx_data_valid (rx_data_valid),
      .stack_rx_data_ready (rx_data_ready)
   );

endmodule

//--- design/eth_tx_framer.sv
/*
 * Transmit framer
 * Builds the Ethernet, IPv4 and UDP headers with the IPv4 checksum,
 * then sends exactly the requested number of payload bytes
 */

`timescale 1ns/1ns

module eth_tx_framer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [47:0]          local_mac,
   input  logic [31:0]          local_ip,
   input  eth_pkg::udp_tx_hdr_t hdr,
   input  logic                 hdr_valid,
   output logic                 hdr_ready,
   input  eth_pkg::byte_beat_t  data,
   input  logic                 data_valid,
   output logic                 data_ready,
   output eth_pkg::byte_beat_t  mac_tx,
   output logic                 mac_tx_valid,
   input  logic                 mac_tx_ready
);
   import eth_pkg::*;

   tx_state_e                  state;
   udp_tx_hdr_t                hdr_q;
   logic [15:0]                csum;
   logic [5:0]                 idx;     // Header byte index
   logic [15:0]                remain;
   logic                       en_q;
   logic [15:0]                ip_len;
   logic [8*HDR_BYTES-1:0]     hdr_bytes;

   // Ones'-complement sum over the fixed and variable IPv4 header words
   function automatic logic [15:0] ip_csum(input logic [15:0] tot_len,
                                           input logic [31:0] src_ip,
                                           input logic [31:0] dst_ip);
      logic [19:0] sum;
      sum = 20'h4500 + 20'h4000 + 20'h4011 + tot_len
          + src_ip[31:16] + src_ip[15:0] + dst_ip[31:16] + dst_ip[15:0];
      sum = sum[15:0] + sum[19:16];
      sum = sum[15:0] + sum[19:16];
      return ~sum[15:0];
   endfunction

   assign ip_len    = hdr_q.length + 16'd28;
   assign hdr_ready = (state == TX_IDLE) && en_q;

   assign hdr_bytes = {
      hdr_q.dst_mac, local_mac, ETHERTYPE_IPV4,
      8'h45, 8'h00, ip_len,            // Version/IHL, TOS, total length
      16'h0000, 16'h4000,              // ID 0, DF set
      8'd64, IP_PROTO_UDP, csum,
      local_ip, hdr_q.dst_ip,
      hdr_q.src_port, hdr_q.dst_port,
      hdr_q.length + 16'd8, 16'h0000   // UDP checksum not used
   };

   always_comb begin
      mac_tx       = '0;
      mac_tx_valid = 1'b0;
      data_ready   = 1'b0;
      case (state)
         TX_HDR: begin
            mac_tx.data  = hdr_bytes[8*(HDR_BYTES - 1 - idx) +: 8];
            mac_tx_valid = 1'b1;
         end
         TX_PAYLOAD: begin
            mac_tx.data  = data.data;
            mac_tx.last  = (remain == 16'd1);  // Payload last is not trusted
            mac_tx_valid = data_valid;
            data_ready   = mac_tx_ready;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state  <= TX_IDLE;
         idx    <= '0;
         remain <= '0;
         en_q   <= 1'b0;
      end else begin
         en_q <= 1'b1;
         case (state)
            TX_IDLE: if (hdr_valid && hdr_ready) begin
               idx   <= '0;
               state <= TX_HDR;
            end
            TX_HDR: if (mac_tx_ready) begin
               idx <= idx + 6'd1;
               if (idx == 6'(HDR_BYTES - 1)) begin
                  remain <= hdr_q.length;
                  state  <= TX_PAYLOAD;
               end
            end
            default: if (mac_tx_valid && mac_tx_ready) begin
               remain <= remain - 16'd1;
               if (remain == 16'd1) state <= TX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_valid && hdr_ready) begin
         hdr_q <= hdr;
         csum  <= ip_csum(hdr.length + 16'd28, local_ip, hdr.dst_ip);
      end
   end

endmodule

//--- design/udp_port_switch.sv
/*
 * UDP port switch
 * Round-robin transmit arbitration over the user ports, one frame per
 * grant, and receive steering by destination port number
 */

`timescale 1ns/1ns

module udp_port_switch #(
   parameter int                  PORT_COUNT = 2,
   parameter eth_pkg::port_list_t PORTS      = '0
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  eth_pkg::udp_tx_hdr_t [PORT_COUNT-1:0] user_tx_hdr,
   input  logic [PORT_COUNT-1:0]                 user_tx_hdr_valid,
   output logic [PORT_COUNT-1:0]                 user_tx_hdr_ready,
   input  eth_pkg::byte_beat_t  [PORT_COUNT-1:0] user_tx_data,
   input  logic [PORT_COUNT-1:0]                 user_tx_data_valid,
   output logic [PORT_COUNT-1:0]                 user_tx_data_ready,
   output eth_pkg::udp_rx_hdr_t [PORT_COUNT-1:0] user_rx_hdr,
   output logic [PORT_COUNT-1:0]                 user_rx_hdr_valid,
   input  logic [PORT_COUNT-1:0]                 user_rx_hdr_ready,
   output eth_pkg::byte_beat_t  [PORT_COUNT-1:0] user_rx_data,
   output logic [PORT_COUNT-1:0]                 user_rx_data_valid,
   input  logic [PORT_COUNT-1:0]                 user_rx_data_ready,
   output eth_pkg::udp_tx_hdr_t                  stack_tx_hdr,
   output logic                                  stack_tx_hdr_valid,
   input  logic                                  stack_tx_hdr_ready,
   output eth_pkg::byte_beat_t                   stack_tx_data,
   output logic                                  stack_tx_data_valid,
   input  logic                                  stack_tx_data_ready,
   input  eth_pkg::udp_rx_hdr_t                  stack_rx_hdr,
   input  logic                                  stack_rx_hdr_valid,
   output logic                                  stack_rx_hdr_ready,
   input  eth_pkg::byte_beat_t                   stack_rx_data,
   input  logic                                  stack_rx_data_valid,
   output logic                                  stack_rx_data_ready
);
   localparam int IW = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1;

   logic [IW-1:0] rr;        // First port to look at
   logic [IW-1:0] gnt;
   logic [IW-1:0] pick;
   logic          found;
   logic          tx_busy;
   logic [IW-1:0] route;
   logic [IW-1:0] hit_idx;
   logic          hit;
   logic          rx_busy;
   logic          discard;

   always_comb begin
      pick  = rr;
      found = 1'b0;
      for (int i = PORT_COUNT - 1; i >= 0; i--) begin  // Nearest to rr wins
         if (user_tx_hdr_valid[(int'(rr) + i) % PORT_COUNT]) begin
            pick  = IW'((int'(rr) + i) % PORT_COUNT);
            found = 1'b1;
         end
      end
   end

   always_comb begin
      hit     = 1'b0;
      hit_idx = '0;
      for (int i = PORT_COUNT - 1; i >= 0; i--) begin
         if (stack_rx_hdr.dst_port == PORTS[i]) begin
            hit     = 1'b1;
            hit_idx = IW'(i);
         end
      end
   end

   assign stack_tx_hdr        = user_tx_hdr[gnt];
   assign stack_tx_hdr_valid  = tx_busy && user_tx_hdr_valid[gnt];
   assign stack_tx_data       = user_tx_data[gnt];
   assign stack_tx_data_valid = tx_busy && user_tx_data_valid[gnt];

   assign stack_rx_hdr_ready  = rx_busy && (discard || user_rx_hdr_ready[route]);
   assign stack_rx_data_ready = rx_busy && (discard || user_rx_data_ready[route]);

   always_comb begin
      for (int i = 0; i < PORT_COUNT; i++) begin
         user_tx_hdr_ready[i]  = tx_busy && gnt == IW'(i) && stack_tx_hdr_ready;
         user_tx_data_ready[i] = tx_busy && gnt == IW'(i) && stack_tx_data_ready;
         user_rx_hdr[i]        = stack_rx_hdr;
         user_rx_data[i]       = stack_rx_data;
         user_rx_hdr_valid[i]  = rx_busy && !discard && route == IW'(i) && stack_rx_hdr_valid;
         user_rx_data_valid[i] = rx_busy && !discard && route == IW'(i) && stack_rx_data_valid;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rr      <= '0;
         gnt     <= '0;
         tx_busy <= 1'b0;
         route   <= '0;
         discard <= 1'b0;
         rx_busy <= 1'b0;
      end else begin
         if (!tx_busy && found) begin
            gnt     <= pick;
            tx_busy <= 1'b1;
         end else if (stack_tx_data_valid && stack_tx_data_ready && stack_tx_data.last) begin
            tx_busy <= 1'b0;
            rr      <= (gnt == IW'(PORT_COUNT - 1)) ? '0 : gnt + 1'b1;
         end
         if (!rx_busy && stack_rx_hdr_valid) begin
            route   <= hit_idx;
            discard <= !hit;   // Unlisted port
            rx_busy <= 1'b1;
         end else if (stack_rx_data_valid && stack_rx_data_ready && stack_rx_data.last) begin
            rx_busy <= 1'b0;
         end
      end
   end

endmodule

//--- dv/eth_tb.sv
/*
 * UDP/IPv4 stack testbench
 * Drives user transmit frames and MAC receive frames from an LFSR,
 * checks mac_tx and the user receive ports against a frame model
 */

`timescale 1ns/1ns

module eth_tb;
   import eth_pkg::*;

   localparam port_list_t  PORTS     = {96'd0, 16'd5678, 16'd1234};
   localparam logic [47:0] LOCAL_MAC = 48'h02_00_5e_10_00_01;
   localparam logic [31:0] LOCAL_IP  = 32'hc0_a8_01_02;
   localparam int          TIMEOUT   = 1000;

   logic                  clk;
   logic                  rst_n;
   byte_beat_t            mac_rx;
   logic                  mac_rx_valid;
   logic                  mac_rx_ready;
   byte_beat_t            mac_tx;
   logic                  mac_tx_valid;
   logic                  mac_tx_ready;
   udp_tx_hdr_t [1:0]     udp_tx_hdr;
   logic [1:0]            udp_tx_hdr_valid;
   logic [1:0]            udp_tx_hdr_ready;
   byte_beat_t  [1:0]     udp_tx_data;
   logic [1:0]            udp_tx_data_valid;
   logic [1:0]            udp_tx_data_ready;
   udp_rx_hdr_t [1:0]     udp_rx_hdr;
   logic [1:0]            udp_rx_hdr_valid;
   logic [1:0]            udp_rx_hdr_ready;
   byte_beat_t  [1:0]     udp_rx_data;
   logic [1:0]            udp_rx_data_valid;
   logic [1:0]            udp_rx_data_ready;
   logic [47:0]           local_mac;
   logic [31:0]           local_ip;

   logic [15:0]           lfsr = 16'd80;
   logic                  random_ready = 1'b0;
   byte_beat_t            exp_tx[2][$];      // Expected mac_tx bytes per source port
   udp_rx_hdr_t           exp_rx_hdr[2][$];
   byte_beat_t            exp_rx_data[2][$];
   byte_beat_t            tx_frame[$];       // mac_tx frame being collected

   tb_clock u_clock (
      .clk   (clk),
      .rst_n (rst_n)
   );

   eth_top #(
      .PORT_COUNT (2),
      .PORTS      (PORTS)
   ) u_dut (
      .clk               (clk),
      .rst_n             (rst_n),
      .mac_rx            (mac_rx),
      .mac_rx_valid      (mac_rx_valid),
      .mac_rx_ready      (mac_rx_ready),
      .mac_tx            (mac_tx),
      .mac_tx_valid      (mac_tx_valid),
      .mac_tx_ready      (mac_tx_ready),
      .udp_tx_hdr        (udp_tx_hdr),
      .udp_tx_hdr_valid  (udp_tx_hdr_valid),
      .udp_tx_hdr_ready  (udp_tx_hdr_ready),
      .udp_tx_data       (udp_tx_data),
      .udp_tx_data_valid (udp_tx_data_valid),
      .udp_tx_data_ready (udp_tx_data_ready),
      .udp_rx_hdr        (udp_rx_hdr),
      .udp_rx_hdr_valid  (udp_rx_hdr_valid),
      .udp_rx_hdr_ready  (udp_rx_hdr_ready),
      .udp_rx_data       (udp_rx_data),
      .udp_rx_data_valid (udp_rx_data_valid),
      .udp_rx_data_ready (udp_rx_data_ready),
      .local_mac         (local_mac),
      .local_ip          (local_ip)
   );

   // Taps x^16 + x^14 + x^13 + x^11 + 1 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_beat(input byte_beat_t got, input byte_beat_t exp, input string what);
      if (got !== exp)
         stop_on_error($sformatf("Fail at %0t: %s got %h/%b, expected %h/%b",
                                 $time, what, got.data, got.last, exp.data, exp.last));
   endtask

   task automatic check_rx_hdr(input udp_rx_hdr_t got, input udp_rx_hdr_t exp, input int p);
      if (got !== exp)
         stop_on_error($sformatf("Fail at %0t: port %0d receive header got %h, expected %h",
                                 $time, p, got, exp));
   endtask

   function automatic logic ready_of(input int kind, input int p);
      case (kind)
         0:       return mac_rx_ready;
         1:       return udp_tx_hdr_ready[p];
         default: return udp_tx_data_ready[p];
      endcase
   endfunction

   // Entered 2 ns after a rising edge with valid up and left 2 ns after the transfer edge
   task automatic wait_transfer(input int kind, input int p, input string what);
      int t;
      t = 0;
      @(negedge clk);
      while (!ready_of(kind, p)) begin
         t++;
         if (t > TIMEOUT)
            stop_on_error($sformatf("Timeout waiting for the DUT to accept %s", what));
         @(negedge clk);
      end
      @(posedge clk);
      #2;
   endtask

   task automatic idle_gap();
      int n;
      n = 0;
      if (random_ready && rand_bits(1) != 0)
         n = int'(rand_bits(2));
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   // Header bytes as the MAC sees them with the IPv4 checksum filled in
   task automatic model_tx_header(input int p, input udp_tx_hdr_t h);
      logic [8*HDR_BYTES-1:0] v;
      logic [31:0]            sum;
      byte_beat_t             b;
      v = {h.dst_mac, LOCAL_MAC, ETHERTYPE_IPV4, 16'h4500, 16'(h.length + 16'd28),
           16'h0000, 16'h4000, 8'd64, IP_PROTO_UDP, 16'h0000, LOCAL_IP, h.dst_ip,
           h.src_port, h.dst_port, 16'(h.length + 16'd8), 16'h0000};
      sum = 0;
      for (int i = 0; i < 10; i++)
         sum += v[8*(HDR_BYTES - 14) - 1 - 16*i -: 16];  // IPv4 header words
      sum = sum[15:0] + sum[31:16];
      sum = sum[15:0] + sum[31:16];
      v[8*(HDR_BYTES - 24) - 1 -: 16] = ~sum[15:0];
      for (int i = 0; i < HDR_BYTES; i++) begin
         b.data = v[8*(HDR_BYTES - i) - 1 -: 8];
         b.last = 1'b0;
         exp_tx[p].push_back(b);
      end
   endtask

   task automatic send_tx_frame(input int p);
      udp_tx_hdr_t h;
      byte_beat_t  b;
      int          len;
      len        = 1 + int'(rand_bits(6)) % 40;
      h          = '0;
      h.dst_mac  = {16'(rand_bits(16)), rand_bits(32)};
      h.dst_ip   = rand_bits(32);
      h.src_port = PORTS[p];  // Tells the frames of the two ports apart on mac_tx
      h.dst_port = 16'(rand_bits(16));
      h.length   = 16'(len);
      model_tx_header(p, h);
      idle_gap();
      udp_tx_hdr[p]       = h;
      udp_tx_hdr_valid[p] = 1'b1;
      wait_transfer(1, p, "a transmit header");
      udp_tx_hdr_valid[p] = 1'b0;
      for (int i = 0; i < len; i++) begin
         b.data = 8'(rand_bits(8));
         b.last = (i == len - 1);
         exp_tx[p].push_back(b);
         idle_gap();
         udp_tx_data[p]       = b;
         udp_tx_data_valid[p] = 1'b1;
         wait_transfer(2, p, "a transmit payload byte");
         udp_tx_data_valid[p] = 1'b0;
      end
   endtask

   // Kind 0 or 1 is a good frame for PORTS[kind]
   // Kind 2 has an unlisted port, 3 a bad EtherType and 4 a bad destination IP
   task automatic send_rx_frame(input int kind, input int len_req);
      logic [8*HDR_BYTES-1:0] v;
      udp_rx_hdr_t            h;
      byte_beat_t             b;
      byte_beat_t             e;
      logic [47:0]            dmac;
      int                     len;
      int                     total;
      len        = (len_req > 0) ? len_req : 1 + int'(rand_bits(6)) % 40;
      h.src_mac  = {16'(rand_bits(16)), rand_bits(32)};
      h.src_ip   = rand_bits(32);
      h.src_port = 16'(rand_bits(16));
      h.dst_port = (kind == 2) ? 16'd4321 : PORTS[kind % 2];  // Bad frames still aim at a port
      h.length   = 16'(len);
      dmac       = (rand_bits(1) != 0) ? 48'hffff_ffff_ffff : LOCAL_MAC;
      v = {dmac, h.src_mac, (kind == 3) ? 16'h86dd : ETHERTYPE_IPV4, 16'h4500,
           16'(len + 28), 16'h0000, 16'h4000, 8'd64, IP_PROTO_UDP, 16'h0000, h.src_ip,
           (kind == 4) ? LOCAL_IP ^ 32'h100 : LOCAL_IP, h.src_port, h.dst_port,
           16'(len + 8), 16'h0000};
      if (kind < 2)
         exp_rx_hdr[kind].push_back(h);
      total = (HDR_BYTES + len < 60) ? 60 : HDR_BYTES + len;  // Minimum frame padding
      for (int i = 0; i < total; i++) begin
         b.data = (i < HDR_BYTES) ? v[8*(HDR_BYTES - i) - 1 -: 8] : 8'(rand_bits(8));
         b.last = (i == total - 1);
         if (kind < 2 && i >= HDR_BYTES && i < HDR_BYTES + len) begin
            e.data = b.data;
            e.last = (i == HDR_BYTES + len - 1);
            exp_rx_data[kind].push_back(e);
         end
         idle_gap();
         mac_rx       = b;
         mac_rx_valid = 1'b1;
         wait_transfer(0, 0, "a receive byte on mac_rx");
         mac_rx_valid = 1'b0;
      end
   endtask

   task automatic check_tx_frame();
      int p;
      if (tx_frame.size() < 36) begin
         stop_on_error("A frame on mac_tx ended inside its header");
      end else begin
         p = ({tx_frame[34].data, tx_frame[35].data} == PORTS[1]) ? 1 : 0;
         foreach (tx_frame[i]) begin
            if (exp_tx[p].size() == 0)
               stop_on_error($sformatf("mac_tx sent more bytes than port %0d queued", p));
            else
               check_beat(tx_frame[i], exp_tx[p].pop_front(), $sformatf("mac_tx byte %0d", i));
         end
         tx_frame.delete();
      end
   endtask

   function automatic int pending();
      return exp_tx[0].size() + exp_tx[1].size() + exp_rx_hdr[0].size()
           + exp_rx_hdr[1].size() + exp_rx_data[0].size() + exp_rx_data[1].size();
   endfunction

   task automatic wait_drained();
      int t;
      t = 0;
      while (pending() != 0) begin
         t++;
         if (t > 2 * TIMEOUT)
            stop_on_error("Timeout: expected output never came out of the DUT");
         @(posedge clk);
      end
      @(posedge clk);
      #2;
   endtask

   // Collects mac_tx beats into frames and checks each whole frame
   always @(negedge clk) begin
      if (rst_n && mac_tx_valid && mac_tx_ready) begin
         tx_frame.push_back(mac_tx);
         if (mac_tx.last)
            check_tx_frame();
         else if (tx_frame.size() > HDR_BYTES + 40)
            stop_on_error("A frame on mac_tx ran past the longest frame sent");
      end
   end

   always @(negedge clk) begin
      for (int p = 0; p < 2; p++) begin
         if (rst_n && udp_rx_hdr_valid[p] && udp_rx_hdr_ready[p]) begin
            if (exp_rx_hdr[p].size() == 0)
               stop_on_error($sformatf("Port %0d received a header it should not get", p));
            else
               check_rx_hdr(udp_rx_hdr[p], exp_rx_hdr[p].pop_front(), p);
         end
         if (rst_n && udp_rx_data_valid[p] && udp_rx_data_ready[p]) begin
            if (exp_rx_data[p].size() == 0)
               stop_on_error($sformatf("Port %0d received a byte it should not get", p));
            else
               check_beat(udp_rx_data[p], exp_rx_data[p].pop_front(),
                          $sformatf("port %0d receive byte", p));
         end
      end
   end

   // Sink ready signals get random low phases once enabled
   always begin
      @(posedge clk);
      #2;
      if (random_ready) begin
         mac_tx_ready      = (rand_bits(2) != 0);
         udp_rx_hdr_ready  = 2'(rand_bits(2));
         udp_rx_data_ready = 2'(rand_bits(2)) | 2'(rand_bits(2));
      end
   end

   initial begin
      int t;
      mac_rx            = '0;
      mac_rx_valid      = 1'b0;
      mac_tx_ready      = 1'b1;
      udp_tx_hdr        = '0;
      udp_tx_hdr_valid  = '0;
      udp_tx_data       = '0;
      udp_tx_data_valid = '0;
      udp_rx_hdr_ready  = 2'b11;
      udp_rx_data_ready = 2'b11;
      local_mac         = LOCAL_MAC;
      local_ip          = LOCAL_IP;
      t = 0;
      while (rst_n !== 1'b1) begin
         t++;
         if (t > 20)
            stop_on_error("Timeout: reset was never released");
         @(posedge clk);
      end
      #2;

      send_tx_frame(0);
      wait_drained();
      fork  // Both ports compete for the framer
         repeat (3) send_tx_frame(0);
         repeat (3) send_tx_frame(1);
      join
      wait_drained();

      send_rx_frame(1, 5);  // Short payload, padded frame
      send_rx_frame(3, 0);
      send_rx_frame(4, 0);
      send_rx_frame(2, 0);
      send_rx_frame(0, 0);
      send_rx_frame(1, 0);
      wait_drained();

      random_ready = 1'b1;
      fork
         repeat (6) send_tx_frame(0);
         repeat (6) send_tx_frame(1);
         repeat (12) send_rx_frame(int'(rand_bits(3)) % 5, 0);
      join
      wait_drained();

      if (pending() == 0 && tx_frame.size() == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         stop_on_error("Output was left over at the end of the test");
      end
   end

endmodule

//--- dv/tb_clock.sv
/*
 * Testbench clock and reset
 * 40 ns clock, rst_n held low for the first 3 cycles
 */

`timescale 1ns/1ns

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #2 rst_n = 1'b1;  // Released with the other inputs
   end

endmodule
